/* hw/asi_macros.svh */
`ifndef ASI_MACROS_SVH
`define ASI_MACROS_SVH

// Bits per 8b10b line symbol
// Also clk cycles per character slot
`define ASI_SYM_BITS 10

// Byte FIFO size, depth a power of two
`define ASI_FIFO_DEPTH 16
`define ASI_FIFO_AW 4

// K28.5 comma byte, sent with K flag set
`define ASI_COMMA 8'hBC

`endif

/* hw/asi_pkg.sv */
`include "asi_macros.svh"

package asi_pkg;

	////////////////////////////////////////////////////////////////////
	// Data path widths
	////////////////////////////////////////////////////////////////////

	// Transport stream byte
	typedef logic [7:0] ts_byte_t;

	// Character before encoding
	// Bit 8 is the K flag, bits 7:0 the byte
	typedef logic [8:0] asi_char_t;

	// Encoded symbol, bit 0 goes out first
	typedef logic [9:0] asi_sym_t;

	// FIFO pointer with wrap bit on top
	typedef logic [`ASI_FIFO_AW:0] fifo_ptr_t;

	////////////////////////////////////////////////////////////////////
	// Scheduler
	////////////////////////////////////////////////////////////////////

	// What the current slot carries
	typedef enum logic {
		SCHED_COMMA,
		SCHED_DATA
	} sched_state_t;

endpackage

/* hw/asi_byte_fifo.sv */
`include "asi_macros.svh"

module asi_byte_fifo (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wr_en,
	input  asi_pkg::ts_byte_t  wr_data,
	input  logic               pop,
	output asi_pkg::ts_byte_t  rd_data,
	output logic               empty,
	output logic               full,
	output logic               overflow
);

	localparam int AW = `ASI_FIFO_AW;

	// Byte storage
	asi_pkg::ts_byte_t mem [`ASI_FIFO_DEPTH];

	// Extended pointers, top bit flips on each wrap
	asi_pkg::fifo_ptr_t wr_ptr;
	asi_pkg::fifo_ptr_t rd_ptr;

	logic wr_ok;
	logic rd_ok;

	// Same address, same lap means nothing stored
	assign empty = (wr_ptr == rd_ptr);
	// Same address, different lap means every entry in use
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// Pop ignored on empty
	assign rd_ok = pop && !empty;
	// Full FIFO still takes a write when a pop frees a slot on the same edge
	assign wr_ok = wr_en && (!full || rd_ok);

	// Show-ahead, head byte always on rd_data
	assign rd_data = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Dropped byte, sticky until reset
			if (wr_en && !wr_ok) begin
				overflow <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr[AW-1:0]] <= wr_data;
		end
	end

endmodule

/* hw/asi_char_scheduler.sv */
`include "asi_macros.svh"

module asi_char_scheduler (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               empty,
	input  asi_pkg::ts_byte_t  rd_data,
	output logic               pop,
	output asi_pkg::asi_char_t char_out,
	output logic               char_ce
);

	localparam int CNT_W = $clog2(`ASI_SYM_BITS);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`ASI_SYM_BITS - 1);

	logic [CNT_W-1:0]       slot_cnt;
	logic                   slot_ce;
	asi_pkg::sched_state_t  state;
	asi_pkg::ts_byte_t      data_q;

	////////////////////////////////////////////////////////////////////
	// Slot timing
	////////////////////////////////////////////////////////////////////

	// Counter starts from zero in reset
	// So the first slot enable lands nine cycles after reset release
	assign slot_ce = (slot_cnt == CNT_LAST);

	// Take the head byte only when one is there
	assign pop = slot_ce && !empty;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot_cnt <= '0;
			state    <= asi_pkg::SCHED_COMMA;
			char_ce  <= 1'b0;
		end else begin
			if (slot_ce) begin
				slot_cnt <= '0;
			end else begin
				slot_cnt <= slot_cnt + 1'b1;
			end
			char_ce <= slot_ce;
			// Record what this slot carries
			if (slot_ce) begin
				if (empty) begin
					state <= asi_pkg::SCHED_COMMA;
				end else begin
					state <= asi_pkg::SCHED_DATA;
				end
			end
		end
	end

	// Payload capture
	always_ff @(posedge clk) begin
		if (pop) begin
			data_q <= rd_data;
		end
	end

	// Idle slots send K28.5
	assign char_out = (state == asi_pkg::SCHED_DATA) ? {1'b0, data_q} : {1'b1, `ASI_COMMA};

endmodule

/* hw/enc_8b10b.sv */
module enc_8b10b (
	input  logic               clk,
	input  logic               rst_n,
	input  asi_pkg::asi_char_t char_in,
	input  logic               char_ce,
	output asi_pkg::asi_sym_t  sym,
	output logic               sym_ce
);

	////////////////////////////////////////////////////////////////////
	// Code tables, RD- column
	////////////////////////////////////////////////////////////////////

	// abcdei, a in the MSB
	function automatic logic [5:0] enc6_neg(input logic [4:0] x);
		case (x)
			5'd0:  enc6_neg = 6'b100111;
			5'd1:  enc6_neg = 6'b011101;
			5'd2:  enc6_neg = 6'b101101;
			5'd3:  enc6_neg = 6'b110001;
			5'd4:  enc6_neg = 6'b110101;
			5'd5:  enc6_neg = 6'b101001;
			5'd6:  enc6_neg = 6'b011001;
			5'd7:  enc6_neg = 6'b111000;
			5'd8:  enc6_neg = 6'b111001;
			5'd9:  enc6_neg = 6'b100101;
			5'd10: enc6_neg = 6'b010101;
			5'd11: enc6_neg = 6'b110100;
			5'd12: enc6_neg = 6'b001101;
			5'd13: enc6_neg = 6'b101100;
			5'd14: enc6_neg = 6'b011100;
			5'd15: enc6_neg = 6'b010111;
			5'd16: enc6_neg = 6'b011011;
			5'd17: enc6_neg = 6'b100011;
			5'd18: enc6_neg = 6'b010011;
			5'd19: enc6_neg = 6'b110010;
			5'd20: enc6_neg = 6'b001011;
			5'd21: enc6_neg = 6'b101010;
			5'd22: enc6_neg = 6'b011010;
			5'd23: enc6_neg = 6'b111010;
			5'd24: enc6_neg = 6'b110011;
			5'd25: enc6_neg = 6'b100110;
			5'd26: enc6_neg = 6'b010110;
			5'd27: enc6_neg = 6'b110110;
			5'd28: enc6_neg = 6'b001110;
			5'd29: enc6_neg = 6'b101110;
			5'd30: enc6_neg = 6'b011110;
			default: enc6_neg = 6'b101011;
		endcase
	endfunction

	// fghj, f in the MSB; alt picks A7 over P7
	function automatic logic [3:0] enc4_neg(input logic [2:0] y, input logic alt);
		case (y)
			3'd0:    enc4_neg = 4'b1011;
			3'd1:    enc4_neg = 4'b1001;
			3'd2:    enc4_neg = 4'b0101;
			3'd3:    enc4_neg = 4'b1100;
			3'd4:    enc4_neg = 4'b1101;
			3'd5:    enc4_neg = 4'b1010;
			3'd6:    enc4_neg = 4'b0110;
			default: enc4_neg = alt ? 4'b0111 : 4'b1110;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////
	// Encoding
	////////////////////////////////////////////////////////////////////

	logic [4:0] x;
	logic [2:0] y;
	logic [5:0] code6;
	logic [3:0] code4;
	logic       unbal6;
	logic       unbal4;
	logic       alt7;
	// Running disparity, high means RD+
	logic       rd_pos;
	logic       rd_mid;
	logic       rd_next;

	assign x = char_in[4:0];
	assign y = char_in[7:5];

	always_comb begin
		// 5b/6b sub-block
		code6  = enc6_neg(x);
		unbal6 = ($countones(code6) != 3);
		// D.07 is balanced but still flips under RD+
		if (rd_pos && (unbal6 || x == 5'd7)) begin
			code6 = ~code6;
		end
		rd_mid = unbal6 ? ~rd_pos : rd_pos;

		// A7 avoids a run of five in e i f g h
		alt7 = (!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
			(rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14));

		// 3b/4b sub-block
		code4  = enc4_neg(y, alt7);
		unbal4 = ($countones(code4) != 2);
		// D.x.3 same story as D.07
		if (rd_mid && (unbal4 || y == 3'd3)) begin
			code4 = ~code4;
		end
		rd_next = unbal4 ? ~rd_mid : rd_mid;

		// Only control character is K28.5, always flips RD
		if (char_in[8]) begin
			code6   = rd_pos ? 6'b110000 : 6'b001111;
			code4   = rd_pos ? 4'b0101 : 4'b1010;
			rd_next = ~rd_pos;
		end
	end

	// Bit a lands in sym[0], j in sym[9]
	always_ff @(posedge clk) begin
		if (char_ce) begin
			sym <= {code4[0], code4[1], code4[2], code4[3],
				code6[0], code6[1], code6[2], code6[3], code6[4], code6[5]};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_pos <= 1'b0;
			sym_ce <= 1'b0;
		end else begin
			sym_ce <= char_ce;
			if (char_ce) begin
				rd_pos <= rd_next;
			end
		end
	end

endmodule

/* hw/ser_10b1b.sv */
module ser_10b1b (
	input  logic              clk,
	input  logic              rst_n,
	input  asi_pkg::asi_sym_t sym,
	input  logic              sym_ce,
	output logic              asi_p,
	output logic              asi_n,
	output logic              frame_start
);

	// Bit on the line is always sr[0]
	asi_pkg::asi_sym_t sr;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// Line idles low until the first symbol
			sr          <= '0;
			frame_start <= 1'b0;
		end else begin
			if (sym_ce) begin
				sr <= sym;
			end else begin
				// LSB first, zero fill behind
				sr <= {1'b0, sr[9:1]};
			end
			// Marks the cycle carrying bit 0
			frame_start <= sym_ce;
		end
	end

	// Differential pair
	assign asi_p = sr[0];
	assign asi_n = ~sr[0];

endmodule

/* hw/asi_tx.sv */
module asi_tx (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              ts_valid,
	input  asi_pkg::ts_byte_t ts_data,
	output logic              asi_p,
	output logic              asi_n,
	output logic              frame_start,
	output logic              overflow
);

	// FIFO to scheduler
	asi_pkg::ts_byte_t  fifo_rd_data;
	logic               fifo_empty;
	logic               fifo_pop;

	// Scheduler to encoder
	asi_pkg::asi_char_t char_q;
	logic               char_ce;

	// Encoder to serializer
	asi_pkg::asi_sym_t  sym;
	logic               sym_ce;

	////////////////////////////////////////////////////////////////////
	// Byte buffer, no back-pressure to the source
	////////////////////////////////////////////////////////////////////

	asi_byte_fifo fifo_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (ts_valid),
		.wr_data  (ts_data),
		.pop      (fifo_pop),
		.rd_data  (fifo_rd_data),
		.empty    (fifo_empty),
		.full     (),
		.overflow (overflow)
	);

	// Data or comma once per slot
	asi_char_scheduler sched_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.empty    (fifo_empty),
		.rd_data  (fifo_rd_data),
		.pop      (fifo_pop),
		.char_out (char_q),
		.char_ce  (char_ce)
	);

	enc_8b10b enc_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.char_in (char_q),
		.char_ce (char_ce),
		.sym     (sym),
		.sym_ce  (sym_ce)
	);

	ser_10b1b ser_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.sym         (sym),
		.sym_ce      (sym_ce),
		.asi_p       (asi_p),
		.asi_n       (asi_n),
		.frame_start (frame_start)
	);

endmodule

/* verif/asi_tx_tb.sv */
`include "asi_macros.svh"

module asi_tx_tb;

	localparam int DRV = 10;
	localparam int FIRST_SYM = 12;
	localparam int N_ORDERED = 8;
	localparam int N_RANDOM = 200;
	localparam int N_BURST = 40;
	localparam int N_RESET = 6;
	localparam int TOTAL_BYTES = N_ORDERED + N_RANDOM + N_BURST + N_RESET;
	localparam int MAX_CYCLES = 20 * `ASI_SYM_BITS * (TOTAL_BYTES + 40);

	// Bytes that hit the A7, D.x.7, D.x.3 and D28 corners
	localparam logic [7:0] ORDERED [N_ORDERED] = '{
		8'hF1, 8'hEB, 8'h07, 8'h63, 8'hFF, 8'h00, 8'hBC, 8'hF4
	};

	// RD- 5b/6b codes, abcdei with a in the MSB
	localparam logic [5:0] CODE6 [32] = '{
		6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
		6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
		6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
		6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
	};
	// RD- 3b/4b codes, fghj with f in the MSB, P7 in the last entry
	localparam logic [3:0] CODE4 [8] = '{
		4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
	};

	logic       clk = 1'b0;
	logic       rst_n;
	logic       ts_valid;
	logic [7:0] ts_data;
	logic       asi_p;
	logic       asi_n;
	logic       frame_start;
	logic       overflow;

	// Reference model state
	logic [7:0] model_q [$];
	logic       model_rd;
	int         fifo_cnt;
	int         dropped;
	int         cyc = -1;
	int         total_cycles;
	logic       pop_now;

	// Line receiver state
	logic [9:0] rx_bits;
	logic [9:0] last_rx;
	int         bit_cnt;
	int         rx_syms;
	logic       n_exp;
	logic       fs_exp;

	int         i;
	logic [9:0] comma_neg;
	logic       rd_dummy;

	asi_tx asi_tx_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.ts_valid    (ts_valid),
		.ts_data     (ts_data),
		.asi_p       (asi_p),
		.asi_n       (asi_n),
		.frame_start (frame_start),
		.overflow    (overflow)
	);

	always #50 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Reference encoder and checks
	//////////////////////////////////////////////////////////////////////

	// Symbol comes back in line order, bit 0 is a
	function automatic logic [9:0] encode_ref(input logic [8:0] ch, input logic rd_in,
		output logic rd_out);
		logic [5:0] c6;
		logic [3:0] c4;
		logic [9:0] s;
		logic       rd6;
		logic       a7;
		int         k;
		if (ch[8]) begin
			// K28.5 in both forms
			c6 = rd_in ? 6'b110000 : 6'b001111;
			c4 = rd_in ? 4'b0101 : 4'b1010;
		end else begin
			c6 = CODE6[ch[4:0]];
			if (rd_in && ($countones(c6) == 4 || ch[4:0] == 5'd7)) begin
				c6 = ~c6;
			end
			rd6 = ($countones(c6) == 3) ? rd_in : !rd_in;
			if (rd6) begin
				a7 = (ch[4:0] == 5'd11) || (ch[4:0] == 5'd13) || (ch[4:0] == 5'd14);
			end else begin
				a7 = (ch[4:0] == 5'd17) || (ch[4:0] == 5'd18) || (ch[4:0] == 5'd20);
			end
			c4 = (ch[7:5] == 3'd7 && a7) ? 4'b0111 : CODE4[ch[7:5]];
			if (rd6 && ($countones(c4) == 3 || ch[7:5] == 3'd3)) begin
				c4 = ~c4;
			end
		end
		for (k = 0; k < 6; k++) begin
			s[k] = c6[5 - k];
		end
		for (k = 0; k < 4; k++) begin
			s[6 + k] = c4[3 - k];
		end
		// Whole-symbol balance sets the next disparity
		case ($countones(s))
			6:       rd_out = 1'b1;
			4:       rd_out = 1'b0;
			default: rd_out = rd_in;
		endcase
		return s;
	endfunction

	task automatic check_value(input logic [9:0] got, input logic [9:0] exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
			$display("Testbench failed");
			$fatal(1, "Check failed, stopping the run");
		end
	endtask

	// Idle versus data depends on slot phase, so a comma is always acceptable
	task automatic compare_symbol(input logic [9:0] rx);
		logic [9:0] comma_sym;
		logic [9:0] data_sym;
		logic       rd_comma;
		logic       rd_data;
		comma_sym = encode_ref({1'b1, `ASI_COMMA}, model_rd, rd_comma);
		last_rx = rx;
		rx_syms++;
		if (model_q.size() == 0 || rx == comma_sym) begin
			check_value(rx, comma_sym, "K28.5 expected");
			model_rd = rd_comma;
		end else begin
			data_sym = encode_ref({1'b0, model_q[0]}, model_rd, rd_data);
			check_value(rx, data_sym, $sformatf("data byte %h", model_q[0]));
			model_rd = rd_data;
			void'(model_q.pop_front());
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Model of the byte FIFO, updated on every edge
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!rst_n) begin
			cyc = -1;
			fifo_cnt = 0;
			dropped = 0;
			model_rd = 1'b0;
			model_q.delete();
		end else begin
			cyc++;
			// Slot edges are 9, 19, 29 after reset release
			pop_now = (cyc % `ASI_SYM_BITS == `ASI_SYM_BITS - 1) && (fifo_cnt > 0);
			if (ts_valid) begin
				if (fifo_cnt < `ASI_FIFO_DEPTH || pop_now) begin
					model_q.push_back(ts_data);
					fifo_cnt++;
				end else begin
					dropped++;
				end
			end
			if (pop_now) begin
				fifo_cnt--;
			end
		end
	end

	// Line deserializer, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst_n || cyc < 0) begin
			bit_cnt = 0;
		end else begin
			n_exp = ~asi_p;
			// Level seen here is the one the next edge, cycle cyc+1, samples
			fs_exp = (cyc + 1 >= FIRST_SYM) &&
				((cyc + 1) % `ASI_SYM_BITS == FIRST_SYM % `ASI_SYM_BITS);
			check_value(asi_n, n_exp, "asi_n is not the complement of asi_p");
			check_value(frame_start, fs_exp, $sformatf("frame_start in cycle %0d", cyc + 1));
			// Line held low until the first symbol
			if (cyc + 1 < FIRST_SYM) begin
				check_value(asi_p, 1'b0, "line idle before first symbol");
			end
			// Sticky overflow follows the dropped bytes
			check_value(overflow, dropped > 0, "overflow against dropped bytes");
			if (frame_start) begin
				rx_bits[0] = asi_p;
				bit_cnt = 1;
			end else if (bit_cnt > 0) begin
				rx_bits[bit_cnt] = asi_p;
				bit_cnt++;
			end
			if (bit_cnt == `ASI_SYM_BITS) begin
				compare_symbol(rx_bits);
				bit_cnt = 0;
			end
		end
	end

	always @(posedge clk) begin
		total_cycles++;
		if (total_cycles >= MAX_CYCLES) begin
			$display("Testbench failed");
			$fatal(1, "Timeout after %0d cycles, the line stopped making progress", total_cycles);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic tick();
		@(posedge clk);
		#DRV;
	endtask

	task automatic send_byte(input logic [7:0] b);
		ts_valid = 1'b1;
		ts_data = b;
		tick();
		ts_valid = 1'b0;
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (8) tick();
		rst_n = 1'b1;
	endtask

	task automatic wait_symbols(input int n);
		int target;
		target = rx_syms + n;
		while (rx_syms < target) begin
			tick();
		end
	endtask

	task automatic wait_drain();
		while (model_q.size() != 0) begin
			tick();
		end
		wait_symbols(2);
	endtask

	initial begin
		rst_n = 1'b0;
		ts_valid = 1'b0;
		ts_data = 8'h00;
		void'($urandom(14));
		comma_neg = encode_ref({1'b1, `ASI_COMMA}, 1'b0, rd_dummy);
		apply_reset();

		// Idle line, commas only
		wait_symbols(6);
		check_value(overflow, 1'b0, "overflow after idle");

		// Spaced single bytes
		for (i = 0; i < N_ORDERED; i++) begin
			send_byte(ORDERED[i]);
			repeat (29) tick();
		end
		wait_drain();

		// One byte per slot never fills the FIFO
		for (i = 0; i < N_RANDOM; i++) begin
			send_byte(8'($urandom));
			repeat (`ASI_SYM_BITS - 1) tick();
			check_value(overflow, 1'b0, "overflow during paced stream");
		end
		wait_drain();

		// Back-to-back burst overruns the FIFO
		for (i = 0; i < N_BURST; i++) begin
			send_byte(8'(8'h40 + i));
		end
		check_value(overflow, 1'b1, "overflow after burst");
		wait_drain();

		// Reset with traffic in flight
		for (i = 0; i < N_RESET; i++) begin
			send_byte(8'($urandom));
			repeat (4) tick();
		end
		apply_reset();
		check_value(overflow, 1'b0, "overflow after reset");
		wait_symbols(1);
		check_value(last_rx, comma_neg, "first symbol after reset");
		wait_symbols(3);

		$display("Testbench passed");
		$finish;
	end

endmodule

/* compile.f */
+incdir+hw
hw/asi_pkg.sv
hw/asi_byte_fifo.sv
hw/asi_char_scheduler.sv
hw/enc_8b10b.sv
hw/ser_10b1b.sv
hw/asi_tx.sv
verif/asi_tx_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = asi_tx_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
SOURCES   = $(wildcard hw/*.sv hw/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
